//--- bench/mem_subsystem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_sva #(
    parameter int NB_DATA    = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_DM_ADDR = mips_mem_pkg::NB_DM_ADDR_DEF
) (
    input logic                  i_clock,
    input logic                  i_rst_n,
    input logic                  i_du_flag,
    input logic [NB_DM_ADDR-1:0] i_dm_addr,     // Debug read address
    input logic [NB_DATA-1:0]    i_dm_data,     // Raw word seen by the debug unit
    input logic                  i_branch_taken,
    input logic                  i_reg_write,   // Toward MEM/WB
    input logic                  i_hlt
);

    int fail_count = 0;             // Read by the testbench at the end of the run

    // Word under the debug port holds while the debug unit keeps it
    a_no_write_in_debug: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_du_flag && $past(i_du_flag) && $past(i_rst_n) && (i_dm_addr == $past(i_dm_addr))
        |-> (i_dm_data == $past(i_dm_data)))
    else begin
        $error("memory word changed while the debug unit holds the port");
        fail_count++;
    end

    a_ctrl_low_in_reset: assert property (@(posedge i_clock)
        !i_rst_n |-> !i_branch_taken && !i_reg_write && !i_hlt)
    else begin
        $error("control output high during reset");
        fail_count++;
    end

endmodule

bind mem_stage mem_subsystem_sva #(
    .NB_DATA        (NB_DATA),
    .NB_DM_ADDR     (NB_DM_ADDR)
) sva_i (
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_du_flag      (i_du_flag),
    .i_dm_addr      (i_dm_read_address),
    .i_dm_data      (o_dm_read_data),
    .i_branch_taken (o_branch_taken),
    .i_reg_write    (o_mem_wb.reg_write),
    .i_hlt          (o_mem_wb.hlt)
);

`default_nettype wire

//--- bench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
    import mips_mem_pkg::*;

    localparam int NB_DATA       = NB_DATA_DEF;
    localparam int NB_ADDR       = NB_ADDR_DEF;
    localparam int NB_PC         = NB_PC_DEF;
    localparam int NB_DM_ADDR    = NB_DM_ADDR_DEF;
    localparam int NB_REG        = NB_REG_DEF;
    localparam int CLK_PERIOD    = 40;
    localparam int RST_CYCLES    = 2;
    localparam int N_WORDS       = 2 ** NB_DM_ADDR;
    localparam int SCAN_CYCLES   = N_WORDS + 3;     // Two idles, the scan, one idle
    localparam int N_WORD_PAIRS  = 8;
    localparam int N_RANDOM      = 120;
    localparam int N_DEBUG       = 16;
    localparam int TEST_CYCLES   = RST_CYCLES + 2 * SCAN_CYCLES + 2 * N_WORD_PAIRS
                                   + N_RANDOM + N_DEBUG + 3 + 6;
    localparam int MARGIN_CYCLES = 20;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_read;
        logic                  mem_write;
        logic                  sgn;
        mem_size_e             size;
        logic                  branch;
        logic                  zero;
        logic [NB_PC-1:0]      branch_addr;
        logic [NB_ADDR-1:0]    alu;
        logic [NB_DATA-1:0]    wdata;
        logic [NB_REG-1:0]     sel_reg;
        logic                  r31_ctrl;
        logic [NB_PC-1:0]      pc;
        logic                  hlt;
    } item_t;

    typedef struct packed {
        logic                  valid;           // Low for the entries before the first item
        logic                  wb_en;
        logic [NB_REG-1:0]     wb_reg;
        logic [NB_DATA-1:0]    wb_data;
        logic                  hlt;
        logic                  br_taken;
        logic [NB_PC-1:0]      br_addr;
        logic                  dbg_chk;
        logic [NB_DATA-1:0]    dbg_data;
    } expect_t;

    logic                  i_clock;
    logic                  i_rst_n;
    logic                  i_reg_write;
    logic                  i_mem_to_reg;
    logic                  i_mem_read;
    logic                  i_mem_write;
    logic                  i_signed;
    mem_size_e             i_size;
    logic                  i_branch;
    logic                  i_zero;
    logic [NB_PC-1:0]      i_branch_addr;
    logic [NB_ADDR-1:0]    i_alu_result;
    logic [NB_DATA-1:0]    i_write_data;
    logic [NB_REG-1:0]     i_selected_reg;
    logic                  i_r31_ctrl;
    logic [NB_PC-1:0]      i_pc;
    logic                  i_hlt;
    logic                  i_du_flag;
    logic                  i_dm_enable;
    logic                  i_dm_read_enable;
    logic [NB_DM_ADDR-1:0] i_dm_read_address;
    logic [NB_DATA-1:0]    o_dm_read_data;
    logic                  o_branch_taken;
    logic [NB_PC-1:0]      o_branch_addr;
    logic [NB_DATA-1:0]    o_wb_data;
    logic [NB_REG-1:0]     o_wb_reg;
    logic                  o_wb_en;
    logic                  o_hlt;

    logic [NB_DATA-1:0]    shadow [N_WORDS];    // Expected memory contents
    expect_t               exp_q [$];           // Oldest entry is the one in writeback
    logic [15:0]           lfsr_state;
    int                    errors;
    int                    checks;
    int                    total;
    item_t                 it;
    logic [NB_DM_ADDR-1:0] addr;
    logic [NB_DM_ADDR-1:0] dbg_addr;

    mem_subsystem_top #(
        .NB_DATA (NB_DATA), .NB_ADDR (NB_ADDR), .NB_PC (NB_PC),
        .NB_DM_ADDR (NB_DM_ADDR), .NB_REG (NB_REG)
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic mem_size_e pick_size();
        logic [1:0] r;
        r = 2'(rand_bits(2));
        case (r)
            2'd1: return HALF;
            2'd2: return BYTE;
            default: return WORD;
        endcase
    endfunction

    function automatic logic [NB_DATA-1:0] lane_mask(input mem_size_e size);
        case (size)
            BYTE: return 32'h0000_00FF;
            HALF: return 32'h0000_FFFF;
            default: return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic logic [NB_DATA-1:0] merge_store(input logic [NB_DATA-1:0] old_word,
                                                       input logic [NB_DATA-1:0] data,
                                                       input mem_size_e size);
        logic [NB_DATA-1:0] mask;
        mask = lane_mask(size);
        return (old_word & ~mask) | (data & mask);
    endfunction

    function automatic logic [NB_DATA-1:0] extend_load(input logic [NB_DATA-1:0] word,
                                                       input mem_size_e size,
                                                       input logic sgn);
        logic [NB_DATA-1:0] mask;
        logic               sign_bit;
        mask = lane_mask(size);
        sign_bit = (size == BYTE) ? word[7] : (size == HALF) ? word[15] : 1'b0;
        if (sgn && sign_bit) begin
            return (word & mask) | ~mask;
        end
        return word & mask;
    endfunction

    // Link beats load, load beats ALU
    function automatic logic [NB_DATA-1:0] expected_wb(input item_t t,
                                                       input logic [NB_DATA-1:0] word);
        if (t.r31_ctrl) begin
            return t.pc;
        end
        if (t.mem_to_reg) begin
            return t.mem_read ? extend_load(word, t.size, t.sgn) : '0;
        end
        return t.alu;
    endfunction

    // Kind 0 store, 1 load, 2 ALU result, 3 link
    function automatic item_t random_item(input logic [1:0] kind,
                                          input logic [NB_DM_ADDR-1:0] a);
        item_t t;
        t = '0;
        t.alu         = rand_bits(32);
        t.wdata       = rand_bits(32);
        t.sel_reg     = 5'(rand_bits(5));
        t.pc          = rand_bits(32);
        t.branch      = rand_bits(1);
        t.zero        = rand_bits(1);
        t.branch_addr = rand_bits(32);
        t.hlt         = (rand_bits(3) == 32'd0);
        t.size        = pick_size();
        t.sgn         = rand_bits(1);
        t.alu[NB_DM_ADDR-1:0] = a;
        case (kind)
            2'd0: t.mem_write = 1'b1;
            2'd1: begin
                t.mem_read   = 1'b1;
                t.mem_to_reg = 1'b1;
                t.reg_write  = 1'b1;
            end
            2'd2: t.reg_write = 1'b1;
            default: begin
                t.reg_write  = 1'b1;
                t.r31_ctrl   = 1'b1;
                t.mem_to_reg = rand_bits(1);    // Must lose to the link
            end
        endcase
        return t;
    endfunction

    task automatic issue(input item_t t, input logic du, input logic [NB_DM_ADDR-1:0] da);
        expect_t e;
        @(posedge i_clock);
        i_reg_write       <= t.reg_write;
        i_mem_to_reg      <= t.mem_to_reg;
        i_mem_read        <= t.mem_read;
        i_mem_write       <= t.mem_write;
        i_signed          <= t.sgn;
        i_size            <= t.size;
        i_branch          <= t.branch;
        i_zero            <= t.zero;
        i_branch_addr     <= t.branch_addr;
        i_alu_result      <= t.alu;
        i_write_data      <= t.wdata;
        i_selected_reg    <= t.sel_reg;
        i_r31_ctrl        <= t.r31_ctrl;
        i_pc              <= t.pc;
        i_hlt             <= t.hlt;
        i_du_flag         <= du;
        i_dm_read_address <= da;
        e          = '0;
        e.valid    = 1'b1;
        e.wb_en    = t.reg_write;
        e.wb_reg   = t.sel_reg;
        e.wb_data  = expected_wb(t, shadow[t.alu[NB_DM_ADDR-1:0]]);
        e.hlt      = t.hlt;
        e.br_taken = t.branch & t.zero;
        e.br_addr  = t.branch_addr;
        e.dbg_chk  = du;
        e.dbg_data = shadow[da];
        if (t.mem_write && !du) begin
            shadow[t.alu[NB_DM_ADDR-1:0]] = merge_store(shadow[t.alu[NB_DM_ADDR-1:0]],
                                                        t.wdata, t.size);
        end
        exp_q.push_back(e);
        if (exp_q.size() > 3) begin
            void'(exp_q.pop_front());
        end
    endtask

    // Flush the pipe, then read every word through the debug port
    task automatic debug_scan();
        issue('0, 1'b0, '0);
        issue('0, 1'b0, '0);
        for (int a = 0; a < N_WORDS; a++) begin
            issue('0, 1'b1, NB_DM_ADDR'(a));
        end
        issue('0, 1'b1, '0);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
        errors++;
    endtask

    // Writeback 2 cycles late, branch 1 cycle late, debug read same cycle
    always @(negedge i_clock) begin
        expect_t e_wb;
        expect_t e_br;
        expect_t e_dbg;
        if (exp_q.size() == 3) begin
            e_wb  = exp_q[0];
            e_br  = exp_q[1];
            e_dbg = exp_q[2];
            checks++;
            if (o_wb_en !== e_wb.wb_en) begin
                report_mismatch("o_wb_en", e_wb.wb_en, o_wb_en);
            end
            if (e_wb.valid && e_wb.wb_en && o_wb_data !== e_wb.wb_data) begin
                report_mismatch("o_wb_data", e_wb.wb_data, o_wb_data);
            end
            if (e_wb.valid && e_wb.wb_en && o_wb_reg !== e_wb.wb_reg) begin
                report_mismatch("o_wb_reg", e_wb.wb_reg, o_wb_reg);
            end
            if (o_hlt !== e_wb.hlt) begin
                report_mismatch("o_hlt", e_wb.hlt, o_hlt);
            end
            if (o_branch_taken !== e_br.br_taken) begin
                report_mismatch("o_branch_taken", e_br.br_taken, o_branch_taken);
            end
            if (e_br.valid && o_branch_addr !== e_br.br_addr) begin
                report_mismatch("o_branch_addr", e_br.br_addr, o_branch_addr);
            end
            if (e_dbg.dbg_chk && o_dm_read_data !== e_dbg.dbg_data) begin
                report_mismatch("o_dm_read_data", e_dbg.dbg_data, o_dm_read_data);
            end
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        i_clock           = 1'b0;
        i_rst_n           = 1'b0;
        i_reg_write       = 1'b0;
        i_mem_to_reg      = 1'b0;
        i_mem_read        = 1'b0;
        i_mem_write       = 1'b0;
        i_signed          = 1'b0;
        i_size            = WORD;
        i_branch          = 1'b0;
        i_zero            = 1'b0;
        i_branch_addr     = '0;
        i_alu_result      = '0;
        i_write_data      = '0;
        i_selected_reg    = '0;
        i_r31_ctrl        = 1'b0;
        i_pc              = '0;
        i_hlt             = 1'b0;
        i_du_flag         = 1'b0;
        i_dm_enable       = 1'b1;
        i_dm_read_enable  = 1'b1;
        i_dm_read_address = '0;
        lfsr_state        = 16'd56205;
        errors            = 0;
        checks            = 0;
        for (int a = 0; a < N_WORDS; a++) begin
            shadow[a] = '0;                     // Memory clears on reset
        end
        exp_q.push_back('0);                    // Pipe registers hold reset values
        exp_q.push_back('0);

        repeat (RST_CYCLES) @(posedge i_clock);
        i_rst_n <= 1'b1;

        debug_scan();                           // All zero after reset

        for (int i = 0; i < N_WORD_PAIRS; i++) begin
            addr = 5'(rand_bits(5));
            it = random_item(2'd0, addr);
            it.size = WORD;
            issue(it, 1'b0, '0);
            it = random_item(2'd1, addr);
            it.size = WORD;
            issue(it, 1'b0, '0);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            addr = 5'(rand_bits(4));            // Half the words, more address reuse
            it = random_item(2'(rand_bits(2)), addr);
            issue(it, 1'b0, '0);
        end

        issue('0, 1'b0, '0);
        issue('0, 1'b0, '0);
        for (int i = 0; i < N_DEBUG; i++) begin
            addr = 5'(rand_bits(5));
            it = random_item(2'd0, addr);
            dbg_addr = 5'(rand_bits(5));
            issue(it, 1'b1, dbg_addr);          // Store must be dropped
        end
        issue('0, 1'b1, '0);
        debug_scan();

        it = '0;
        it.hlt = 1'b1;
        issue(it, 1'b0, '0);
        repeat (3) issue('0, 1'b0, '0);

        total = errors + dut_i.mem_stage_i.sva_i.fail_count;
        $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.mem_stage_i.sva_i.fail_count);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/mips_mem_pkg.sv
design/pipe_if.sv
design/ex_mem_reg.sv
design/data_mem_controller.sv
design/data_memory.sv
design/mem_stage.sv
design/mem_wb_stage.sv
design/mem_subsystem_top.sv
bench/mem_subsystem_sva.sv
bench/tb_mem_subsystem.sv

//--- design/data_mem_controller.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_controller #(
    parameter int NB_DATA = mips_mem_pkg::NB_DATA_DEF
) (
    input  logic                    i_signed,       // Sign-extend loads
    input  mips_mem_pkg::mem_size_e i_size,
    input  logic                    i_mem_write,
    input  logic                    i_mem_read,
    input  logic [NB_DATA-1:0]      i_write_data,   // From the datapath
    input  logic [NB_DATA-1:0]      i_read_data,    // Current word in memory
    output logic [NB_DATA-1:0]      o_write_data,   // Merged word to memory
    output logic [NB_DATA-1:0]      o_read_data     // Extended word to writeback
);
    import mips_mem_pkg::*;

    localparam int NB_BYTE = 8;
    localparam int NB_HALF = 16;

    logic byte_sign;
    logic half_sign;

    assign byte_sign = i_signed & i_read_data[NB_BYTE-1];
    assign half_sign = i_signed & i_read_data[NB_HALF-1];

    // Store path, the upper lanes keep the old contents
    always_comb begin
        o_write_data = '0;
        if (i_mem_write) begin
            case (i_size)
                BYTE: begin
                    o_write_data = {i_read_data[NB_DATA-1:NB_BYTE],
                                    i_write_data[NB_BYTE-1:0]};
                end
                HALF: begin
                    o_write_data = {i_read_data[NB_DATA-1:NB_HALF],
                                    i_write_data[NB_HALF-1:0]};
                end
                default: begin
                    o_write_data = i_write_data;    // WORD
                end
            endcase
        end
    end

    // Load path
    always_comb begin
        o_read_data = '0;
        if (i_mem_read) begin
            case (i_size)
                BYTE: begin
                    o_read_data = {{(NB_DATA-NB_BYTE){byte_sign}},
                                   i_read_data[NB_BYTE-1:0]};
                end
                HALF: begin
                    o_read_data = {{(NB_DATA-NB_HALF){half_sign}},
                                   i_read_data[NB_HALF-1:0]};
                end
                default: begin
                    o_read_data = i_read_data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/data_memory.sv
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int NB_DATA    = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_DM_ADDR = mips_mem_pkg::NB_DM_ADDR_DEF
) (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    input  logic                  i_enable,         // Global enable from debug unit
    input  logic                  i_mem_write,
    input  logic                  i_mem_read,
    input  logic [NB_DM_ADDR-1:0] i_address,        // Word address
    input  logic [NB_DATA-1:0]    i_write_data,
    output logic [NB_DATA-1:0]    o_read_data
);

    localparam int N_WORDS = 2 ** NB_DM_ADDR;

    logic [NB_DATA-1:0] mem [N_WORDS];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_enable && i_mem_write) begin
            mem[i_address] <= i_write_data;
        end
    end

    // Asynchronous read
    always_comb begin
        if (i_enable && i_mem_read) begin
            o_read_data = mem[i_address];
        end else begin
            o_read_data = '0;
        end
    end

endmodule

`default_nettype wire

//--- design/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg #(
    parameter int NB_DATA = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_ADDR = mips_mem_pkg::NB_ADDR_DEF,
    parameter int NB_PC   = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_REG  = mips_mem_pkg::NB_REG_DEF
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    input  logic                    i_reg_write,
    input  logic                    i_mem_to_reg,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  logic                    i_signed,
    input  mips_mem_pkg::mem_size_e i_size,
    input  logic                    i_branch,
    input  logic                    i_zero,
    input  logic [NB_PC-1:0]        i_branch_addr,
    input  logic [NB_ADDR-1:0]      i_alu_result,
    input  logic [NB_DATA-1:0]      i_write_data,
    input  logic [NB_REG-1:0]       i_selected_reg,
    input  logic                    i_r31_ctrl,     // Link to r31
    input  logic [NB_PC-1:0]        i_pc,
    input  logic                    i_hlt,
    ex_mem_if.src                   o_ex_mem
);
    import mips_mem_pkg::*;

    wb_src_e wb_src_next;

    // Link wins over a load, a load over the ALU result
    always_comb begin
        if (i_r31_ctrl) begin
            wb_src_next = LINK;
        end else if (i_mem_to_reg) begin
            wb_src_next = MEM;
        end else begin
            wb_src_next = ALU;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem.reg_write <= 1'b0;
            o_ex_mem.mem_read  <= 1'b0;
            o_ex_mem.mem_write <= 1'b0;
            o_ex_mem.branch    <= 1'b0;
            o_ex_mem.hlt       <= 1'b0;
        end else begin
            o_ex_mem.reg_write <= i_reg_write;
            o_ex_mem.mem_read  <= i_mem_read;
            o_ex_mem.mem_write <= i_mem_write;
            o_ex_mem.branch    <= i_branch;
            o_ex_mem.hlt       <= i_hlt;
        end
    end

    always_ff @(posedge i_clock) begin
        o_ex_mem.signed_ld    <= i_signed;
        o_ex_mem.size         <= i_size;
        o_ex_mem.zero         <= i_zero;
        o_ex_mem.branch_addr  <= i_branch_addr;
        o_ex_mem.alu_result   <= i_alu_result;
        o_ex_mem.write_data   <= i_write_data;
        o_ex_mem.selected_reg <= i_selected_reg;
        o_ex_mem.wb_src       <= wb_src_next;
        o_ex_mem.pc           <= i_pc;
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int NB_DATA    = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_PC      = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_DM_ADDR = mips_mem_pkg::NB_DM_ADDR_DEF
) (
    input  logic                  i_clock,
    input  logic                  i_rst_n,
    ex_mem_if.dst                 i_ex_mem,
    input  logic                  i_du_flag,            // Debug unit owns the port
    input  logic                  i_dm_enable,
    input  logic                  i_dm_read_enable,
    input  logic [NB_DM_ADDR-1:0] i_dm_read_address,
    mem_wb_if.src                 o_mem_wb,
    output logic                  o_branch_taken,       // To fetch PC mux
    output logic [NB_PC-1:0]      o_branch_addr,
    output logic [NB_DATA-1:0]    o_dm_read_data        // Raw word to debug unit
);

    logic [NB_DM_ADDR-1:0] address;
    logic                  mem_read;
    logic                  mem_write;
    logic [NB_DATA-1:0]    write_data;
    logic [NB_DATA-1:0]    read_data;
    logic [NB_DATA-1:0]    load_data;

    // Port owner select
    always_comb begin
        if (i_du_flag) begin
            mem_read  = i_dm_read_enable;
            mem_write = 1'b0;                           // Datapath stores dropped
            address   = i_dm_read_address;
        end else begin
            mem_read  = i_ex_mem.mem_read;
            mem_write = i_ex_mem.mem_write;
            address   = i_ex_mem.alu_result[NB_DM_ADDR-1:0];
        end
    end

    data_mem_controller #(
        .NB_DATA      (NB_DATA)
    ) data_mem_controller_i (
        .i_signed     (i_ex_mem.signed_ld),
        .i_size       (i_ex_mem.size),
        .i_mem_write  (mem_write),
        .i_mem_read   (mem_read),
        .i_write_data (i_ex_mem.write_data),
        .i_read_data  (read_data),
        .o_write_data (write_data),
        .o_read_data  (load_data)
    );

    // A store also reads, the old word feeds the lane merge
    data_memory #(
        .NB_DATA      (NB_DATA),
        .NB_DM_ADDR   (NB_DM_ADDR)
    ) data_memory_i (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_dm_enable),
        .i_mem_write  (mem_write),
        .i_mem_read   (mem_read | mem_write),
        .i_address    (address),
        .i_write_data (write_data),
        .o_read_data  (read_data)
    );

    assign o_branch_taken = i_ex_mem.branch & i_ex_mem.zero;
    assign o_branch_addr  = i_ex_mem.branch_addr;
    assign o_dm_read_data = read_data;

    // Toward writeback
    assign o_mem_wb.load_data    = load_data;
    assign o_mem_wb.alu_result   = i_ex_mem.alu_result;
    assign o_mem_wb.selected_reg = i_ex_mem.selected_reg;
    assign o_mem_wb.reg_write    = i_ex_mem.reg_write;
    assign o_mem_wb.wb_src       = i_ex_mem.wb_src;
    assign o_mem_wb.pc           = i_ex_mem.pc;
    assign o_mem_wb.hlt          = i_ex_mem.hlt;

endmodule

`default_nettype wire

//--- design/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
    parameter int NB_DATA    = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_ADDR    = mips_mem_pkg::NB_ADDR_DEF,
    parameter int NB_PC      = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_DM_ADDR = mips_mem_pkg::NB_DM_ADDR_DEF,
    parameter int NB_REG     = mips_mem_pkg::NB_REG_DEF
) (
    input  logic                    i_clock,
    input  logic                    i_rst_n,
    // Execute side
    input  logic                    i_reg_write,
    input  logic                    i_mem_to_reg,
    input  logic                    i_mem_read,
    input  logic                    i_mem_write,
    input  logic                    i_signed,
    input  mips_mem_pkg::mem_size_e i_size,
    input  logic                    i_branch,
    input  logic                    i_zero,
    input  logic [NB_PC-1:0]        i_branch_addr,
    input  logic [NB_ADDR-1:0]      i_alu_result,
    input  logic [NB_DATA-1:0]      i_write_data,
    input  logic [NB_REG-1:0]       i_selected_reg,
    input  logic                    i_r31_ctrl,
    input  logic [NB_PC-1:0]        i_pc,
    input  logic                    i_hlt,
    // Debug unit
    input  logic                    i_du_flag,
    input  logic                    i_dm_enable,
    input  logic                    i_dm_read_enable,
    input  logic [NB_DM_ADDR-1:0]   i_dm_read_address,
    output logic [NB_DATA-1:0]      o_dm_read_data,
    // Fetch
    output logic                    o_branch_taken,
    output logic [NB_PC-1:0]        o_branch_addr,
    // Register bank
    output logic [NB_DATA-1:0]      o_wb_data,
    output logic [NB_REG-1:0]       o_wb_reg,
    output logic                    o_wb_en,
    output logic                    o_hlt
);

    ex_mem_if #(
        .NB_DATA (NB_DATA), .NB_ADDR (NB_ADDR), .NB_PC (NB_PC), .NB_REG (NB_REG)
    ) ex_mem_bus ();

    mem_wb_if #(
        .NB_DATA (NB_DATA), .NB_ADDR (NB_ADDR), .NB_PC (NB_PC), .NB_REG (NB_REG)
    ) mem_wb_bus ();

    ex_mem_reg #(
        .NB_DATA (NB_DATA), .NB_ADDR (NB_ADDR), .NB_PC (NB_PC), .NB_REG (NB_REG)
    ) ex_mem_reg_i (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_reg_write    (i_reg_write),
        .i_mem_to_reg   (i_mem_to_reg),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_signed       (i_signed),
        .i_size         (i_size),
        .i_branch       (i_branch),
        .i_zero         (i_zero),
        .i_branch_addr  (i_branch_addr),
        .i_alu_result   (i_alu_result),
        .i_write_data   (i_write_data),
        .i_selected_reg (i_selected_reg),
        .i_r31_ctrl     (i_r31_ctrl),
        .i_pc           (i_pc),
        .i_hlt          (i_hlt),
        .o_ex_mem       (ex_mem_bus.src)
    );

    mem_stage #(
        .NB_DATA (NB_DATA), .NB_PC (NB_PC), .NB_DM_ADDR (NB_DM_ADDR)
    ) mem_stage_i (
        .i_clock           (i_clock),
        .i_rst_n           (i_rst_n),
        .i_ex_mem          (ex_mem_bus.dst),
        .i_du_flag         (i_du_flag),
        .i_dm_enable       (i_dm_enable),
        .i_dm_read_enable  (i_dm_read_enable),
        .i_dm_read_address (i_dm_read_address),
        .o_mem_wb          (mem_wb_bus.src),
        .o_branch_taken    (o_branch_taken),
        .o_branch_addr     (o_branch_addr),
        .o_dm_read_data    (o_dm_read_data)
    );

    mem_wb_stage #(
        .NB_DATA (NB_DATA), .NB_ADDR (NB_ADDR), .NB_PC (NB_PC), .NB_REG (NB_REG)
    ) mem_wb_stage_i (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_mem_wb  (mem_wb_bus.dst),
        .o_wb_data (o_wb_data),
        .o_wb_reg  (o_wb_reg),
        .o_wb_en   (o_wb_en),
        .o_hlt     (o_hlt)
    );

endmodule

`default_nettype wire

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
    parameter int NB_DATA = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_ADDR = mips_mem_pkg::NB_ADDR_DEF,
    parameter int NB_PC   = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_REG  = mips_mem_pkg::NB_REG_DEF
) (
    input  logic               i_clock,
    input  logic               i_rst_n,
    mem_wb_if.dst              i_mem_wb,
    output logic [NB_DATA-1:0] o_wb_data,       // To register bank
    output logic [NB_REG-1:0]  o_wb_reg,
    output logic               o_wb_en,
    output logic               o_hlt            // Program finished
);
    import mips_mem_pkg::*;

    logic               reg_write_q;
    logic               hlt_q;
    logic [NB_DATA-1:0] load_data_q;
    logic [NB_ADDR-1:0] alu_result_q;
    logic [NB_REG-1:0]  selected_reg_q;
    wb_src_e            wb_src_q;
    logic [NB_PC-1:0]   pc_q;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            reg_write_q <= 1'b0;
            hlt_q       <= 1'b0;
        end else begin
            reg_write_q <= i_mem_wb.reg_write;
            hlt_q       <= i_mem_wb.hlt;
        end
    end

    always_ff @(posedge i_clock) begin
        load_data_q    <= i_mem_wb.load_data;
        alu_result_q   <= i_mem_wb.alu_result;
        selected_reg_q <= i_mem_wb.selected_reg;
        wb_src_q       <= i_mem_wb.wb_src;
        pc_q           <= i_mem_wb.pc;
    end

    // Writeback mux
    always_comb begin
        case (wb_src_q)
            MEM: begin
                o_wb_data = load_data_q;
            end
            LINK: begin
                o_wb_data = NB_DATA'(pc_q);     // Return address
            end
            default: begin
                o_wb_data = NB_DATA'(alu_result_q);
            end
        endcase
    end

    assign o_wb_reg = selected_reg_q;
    assign o_wb_en  = reg_write_q;
    assign o_hlt    = hlt_q;

endmodule

`default_nettype wire

//--- design/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    // Access size of a load or store, lanes always taken from the low end
    typedef enum logic [1:0] {
        WORD = 2'b00,                       // Full 32-bit word
        HALF = 2'b01,                       // Low halfword
        BYTE = 2'b10                        // Low byte
    } mem_size_e;

    // Source of the value written back to the register bank
    typedef enum logic [1:0] {
        ALU  = 2'b00,                       // R-type and immediate results
        MEM  = 2'b01,                       // Loads
        LINK = 2'b10                        // Return address for JAL/JALR
    } wb_src_e;

    // Default widths, overridden only from the top level
    localparam int NB_DATA_DEF    = 32;     // Data word
    localparam int NB_ADDR_DEF    = 32;     // ALU result
    localparam int NB_PC_DEF      = 32;     // Program counter
    localparam int NB_DM_ADDR_DEF = 5;      // 32-word data memory
    localparam int NB_REG_DEF     = 5;      // Register index

endpackage

`default_nettype wire

//--- design/pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

// EX/MEM bundle, driven by the pipeline register and read by the MEM stage
interface ex_mem_if #(
    parameter int NB_DATA = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_ADDR = mips_mem_pkg::NB_ADDR_DEF,
    parameter int NB_PC   = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_REG  = mips_mem_pkg::NB_REG_DEF
) ();
    import mips_mem_pkg::*;

    logic               reg_write;          // WB stage flag
    logic               mem_read;
    logic               mem_write;
    logic               signed_ld;          // Sign-extend loads
    mem_size_e          size;
    logic               branch;
    logic               zero;               // ALU zero flag
    logic [NB_PC-1:0]   branch_addr;
    logic [NB_ADDR-1:0] alu_result;         // Data memory address or result
    logic [NB_DATA-1:0] write_data;         // Store data, operand B in EX
    logic [NB_REG-1:0]  selected_reg;       // rd or rt
    wb_src_e            wb_src;
    logic [NB_PC-1:0]   pc;
    logic               hlt;

    modport src (output reg_write, mem_read, mem_write, signed_ld, size, branch, zero,
                        branch_addr, alu_result, write_data, selected_reg, wb_src, pc, hlt);
    modport dst (input  reg_write, mem_read, mem_write, signed_ld, size, branch, zero,
                        branch_addr, alu_result, write_data, selected_reg, wb_src, pc, hlt);
endinterface

// MEM/WB bundle, driven by the MEM stage and read by the writeback register
interface mem_wb_if #(
    parameter int NB_DATA = mips_mem_pkg::NB_DATA_DEF,
    parameter int NB_ADDR = mips_mem_pkg::NB_ADDR_DEF,
    parameter int NB_PC   = mips_mem_pkg::NB_PC_DEF,
    parameter int NB_REG  = mips_mem_pkg::NB_REG_DEF
) ();
    import mips_mem_pkg::*;

    logic [NB_DATA-1:0] load_data;          // Extended load result
    logic [NB_ADDR-1:0] alu_result;
    logic [NB_REG-1:0]  selected_reg;
    logic               reg_write;
    wb_src_e            wb_src;
    logic [NB_PC-1:0]   pc;
    logic               hlt;

    modport src (output load_data, alu_result, selected_reg, reg_write, wb_src, pc, hlt);
    modport dst (input  load_data, alu_result, selected_reg, reg_write, wb_src, pc, hlt);
endinterface

`default_nettype wire
